//--- common/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Datapath and CSR address widths
`define CSR_XLEN        64
`define CSR_ADDR_W      12

// Machine-mode CSR addresses
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// MPP=11, MXL fields as seen after reset
`define MSTATUS_RESET   32'ha0001800

// mstatus field positions
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MSTATUS_MPP_LO  11  // MPP spans this bit and the next

`endif

//--- common/csr_isa_pkg.sv
`include "csr_consts.svh"
`default_nettype none

package csr_isa_pkg;

    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [2:0]             funct3_t;

    // What the core asks the unit to do
    typedef enum logic [1:0] {
        CMD_CSR  = 2'd0,
        CMD_TRAP = 2'd1,
        CMD_MRET = 2'd2
    } cmd_kind_t;

    // Encoded the same as funct3[1:0]
    typedef enum logic [1:0] {
        OP_WRITE = 2'b01,
        OP_SET   = 2'b10,
        OP_CLEAR = 2'b11
    } csr_op_t;

endpackage

`default_nettype wire

//--- common/csr_ctrl_pkg.sv
`default_nettype none

package csr_ctrl_pkg;

    // Command side, slave of the four-phase port
    typedef enum logic {
        RX_IDLE,
        RX_ACK
    } rx_state_t;

    // Result side, master of the four-phase port
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_LOW
    } tx_state_t;

endpackage

`default_nettype wire

//--- hdl/csr_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_rx (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_req,
    input  wire csr_isa_pkg::cmd_kind_t cmd_kind,
    input  wire csr_isa_pkg::funct3_t   cmd_funct3,
    input  wire csr_isa_pkg::csr_addr_t cmd_addr,
    input  wire csr_isa_pkg::xlen_t     cmd_rs1,
    input  wire [4:0]                   cmd_zimm,
    input  wire csr_isa_pkg::xlen_t     cmd_pc,
    input  wire csr_isa_pkg::xlen_t     cmd_cause,
    input  wire                        dec_take,
    output logic                       cmd_ack,
    output logic                       dec_valid,
    output csr_isa_pkg::cmd_kind_t      dec_kind,
    output csr_isa_pkg::csr_op_t        dec_op,
    output logic                       dec_bad_op,
    output logic                       dec_writes,
    output csr_isa_pkg::csr_addr_t      dec_addr,
    output csr_isa_pkg::xlen_t          dec_operand,
    output csr_isa_pkg::xlen_t          dec_pc,
    output csr_isa_pkg::xlen_t          dec_cause
);
    import csr_isa_pkg::*;
    import csr_ctrl_pkg::*;

    rx_state_t state;
    logic      capture;
    csr_op_t   op_d;
    logic      bad_d;
    logic      writes_d;
    xlen_t     operand_d;

    // Slot free now or drained on this edge
    assign capture = (state == RX_IDLE) && cmd_req && (!dec_valid || dec_take);

    assign operand_d = cmd_funct3[2] ? xlen_t'(cmd_zimm) : cmd_rs1;

    always_comb begin
        bad_d = 1'b0;
        case (cmd_funct3[1:0])
            2'b01:   op_d = OP_WRITE;
            2'b10:   op_d = OP_SET;
            2'b11:   op_d = OP_CLEAR;
            default: begin
                op_d  = OP_WRITE;
                bad_d = 1'b1;
            end
        endcase
        // csrrs/csrrc with x0 or zimm=0 only read
        writes_d = (cmd_kind == CMD_CSR) && !bad_d && (op_d == OP_WRITE || operand_d != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: if (capture) begin
                    state   <= RX_ACK;
                    cmd_ack <= 1'b1;
                end
                RX_ACK: if (!cmd_req) begin
                    state   <= RX_IDLE;
                    cmd_ack <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else if (capture)
            dec_valid <= 1'b1;
        else if (dec_take)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_kind    <= cmd_kind;
            dec_op      <= op_d;
            dec_bad_op  <= bad_d;
            dec_writes  <= writes_d;
            dec_addr    <= cmd_addr;
            dec_operand <= operand_d;
            dec_pc      <= cmd_pc;
            dec_cause   <= cmd_cause;
        end
    end

endmodule

`default_nettype wire

//--- csr_unit/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_consts.svh"
`default_nettype none

module csr_regfile (
    input  wire                        clk,
    input  wire                        rst,
    input  wire csr_isa_pkg::csr_addr_t rd_addr,
    input  wire                        wr_en,
    input  wire csr_isa_pkg::xlen_t     wr_data,
    input  wire                        trap_en,
    input  wire csr_isa_pkg::xlen_t     trap_pc,
    input  wire csr_isa_pkg::xlen_t     trap_cause,
    input  wire                        mret_en,
    output csr_isa_pkg::xlen_t          rd_data,
    output logic                       rd_hit,
    output csr_isa_pkg::xlen_t          mtvec_q,
    output csr_isa_pkg::xlen_t          mepc_q
);
    import csr_isa_pkg::*;

    localparam int MPP_HI = `MSTATUS_MPP_LO + 1;

    xlen_t mstatus_q;
    xlen_t mcause_q;

    // Instruction writes use the read address
    always_comb begin
        rd_hit = 1'b1;
        case (rd_addr)
            `CSR_MSTATUS: rd_data = mstatus_q;
            `CSR_MTVEC:   rd_data = mtvec_q;
            `CSR_MEPC:    rd_data = mepc_q;
            `CSR_MCAUSE:  rd_data = mcause_q;
            default: begin
                rd_data = '0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= xlen_t'(`MSTATUS_RESET);
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_en) begin
            mepc_q   <= trap_pc;
            mcause_q <= trap_cause;
            mstatus_q[MPP_HI:`MSTATUS_MPP_LO] <= 2'b11;      // Enter M-mode
            mstatus_q[`MSTATUS_MPIE]          <= mstatus_q[`MSTATUS_MIE];
            mstatus_q[`MSTATUS_MIE]           <= 1'b0;
        end else if (mret_en) begin
            mstatus_q[MPP_HI:`MSTATUS_MPP_LO] <= 2'b00;
            mstatus_q[`MSTATUS_MIE]           <= mstatus_q[`MSTATUS_MPIE];
            mstatus_q[`MSTATUS_MPIE]          <= 1'b1;
        end else if (wr_en) begin
            case (rd_addr)
                `CSR_MSTATUS: mstatus_q <= wr_data;
                `CSR_MTVEC:   mtvec_q   <= wr_data;
                `CSR_MEPC:    mepc_q    <= wr_data;
                `CSR_MCAUSE:  mcause_q  <= wr_data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- csr_unit/csr_exec.sv
`timescale 1ns/1ps
`default_nettype none

module csr_exec (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        dec_valid,
    input  wire csr_isa_pkg::cmd_kind_t dec_kind,
    input  wire csr_isa_pkg::csr_op_t   dec_op,
    input  wire                        dec_bad_op,
    input  wire                        dec_writes,
    input  wire csr_isa_pkg::csr_addr_t dec_addr,
    input  wire csr_isa_pkg::xlen_t     dec_operand,
    input  wire csr_isa_pkg::xlen_t     dec_pc,
    input  wire csr_isa_pkg::xlen_t     dec_cause,
    input  wire                        ex_take,
    output logic                       dec_take,
    output logic                       ex_valid,
    output csr_isa_pkg::xlen_t          ex_rdata,
    output logic                       ex_err,
    output logic                       ex_jmp,
    output csr_isa_pkg::xlen_t          ex_target
);
    import csr_isa_pkg::*;

    xlen_t old_val;
    xlen_t new_val;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    logic  hit;
    logic  csr_wr;
    logic  trap_en;
    logic  mret_en;
    xlen_t rdata_d;
    xlen_t target_d;
    logic  err_d;
    logic  jmp_d;

    assign dec_take = dec_valid && (!ex_valid || ex_take);

    always_comb begin
        case (dec_op)
            OP_SET:   new_val = old_val | dec_operand;
            OP_CLEAR: new_val = old_val & ~dec_operand;
            default:  new_val = dec_operand;
        endcase
    end

    // CSR state moves only on the edge the item leaves decode
    assign csr_wr  = dec_take && (dec_kind == CMD_CSR) && !dec_bad_op && dec_writes && hit;
    assign trap_en = dec_take && (dec_kind == CMD_TRAP);
    assign mret_en = dec_take && (dec_kind == CMD_MRET);

    always_comb begin
        rdata_d  = '0;
        target_d = '0;
        err_d    = 1'b0;
        jmp_d    = 1'b0;
        case (dec_kind)
            CMD_CSR: begin
                rdata_d = old_val;  // Zero on a miss
                err_d   = dec_bad_op || (!hit && dec_writes);
            end
            CMD_TRAP: begin
                jmp_d    = 1'b1;
                target_d = mtvec_q;
            end
            CMD_MRET: begin
                jmp_d    = 1'b1;
                target_d = mepc_q;
            end
            default: err_d = 1'b1;
        endcase
    end

    csr_regfile i_regfile (
        .clk        (clk),
        .rst        (rst),
        .rd_addr    (dec_addr),
        .wr_en      (csr_wr),
        .wr_data    (new_val),
        .trap_en    (trap_en),
        .trap_pc    (dec_pc),
        .trap_cause (dec_cause),
        .mret_en    (mret_en),
        .rd_data    (old_val),
        .rd_hit     (hit),
        .mtvec_q    (mtvec_q),
        .mepc_q     (mepc_q)
    );

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else if (dec_take)
            ex_valid <= 1'b1;
        else if (ex_take)
            ex_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (dec_take) begin
            ex_rdata  <= rdata_d;
            ex_err    <= err_d;
            ex_jmp    <= jmp_d;
            ex_target <= target_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_resp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module csr_resp_tx (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    ex_valid,
    input  wire csr_isa_pkg::xlen_t ex_rdata,
    input  wire                    ex_err,
    input  wire                    ex_jmp,
    input  wire csr_isa_pkg::xlen_t ex_target,
    input  wire                    res_ack,
    output logic                   ex_take,
    output logic                   res_req,
    output csr_isa_pkg::xlen_t      res_rdata,
    output logic                   res_err,
    output logic                   res_jmp,
    output csr_isa_pkg::xlen_t      res_target
);
    import csr_ctrl_pkg::*;

    tx_state_t state;

    assign ex_take = (state == TX_IDLE) && ex_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            res_req <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: if (ex_take) state <= TX_REQ;
                TX_REQ: begin
                    if (!res_req) begin
                        res_req <= 1'b1;   // One edge after the load
                    end else if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= TX_WAIT_LOW;
                    end
                end
                TX_WAIT_LOW: if (!res_ack) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Holding register, stable for the whole handshake
    always_ff @(posedge clk) begin
        if (ex_take) begin
            res_rdata  <= ex_rdata;
            res_err    <= ex_err;
            res_jmp    <= ex_jmp;
            res_target <= ex_target;
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_pipe_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_req,
    output logic                       cmd_ack,
    input  wire csr_isa_pkg::cmd_kind_t cmd_kind,
    input  wire csr_isa_pkg::funct3_t   cmd_funct3,
    input  wire csr_isa_pkg::csr_addr_t cmd_addr,
    input  wire csr_isa_pkg::xlen_t     cmd_rs1,
    input  wire [4:0]                   cmd_zimm,
    input  wire csr_isa_pkg::xlen_t     cmd_pc,
    input  wire csr_isa_pkg::xlen_t     cmd_cause,
    output logic                       res_req,
    input  wire                        res_ack,
    output csr_isa_pkg::xlen_t          res_rdata,
    output logic                       res_err,
    output logic                       res_jmp,
    output csr_isa_pkg::xlen_t          res_target
);
    import csr_isa_pkg::*;

    // Decode slot
    logic      dec_valid;
    logic      dec_take;
    cmd_kind_t dec_kind;
    csr_op_t   dec_op;
    logic      dec_bad_op;
    logic      dec_writes;
    csr_addr_t dec_addr;
    xlen_t     dec_operand;
    xlen_t     dec_pc;
    xlen_t     dec_cause;

    // Execute slot
    logic      ex_valid;
    logic      ex_take;
    xlen_t     ex_rdata;
    logic      ex_err;
    logic      ex_jmp;
    xlen_t     ex_target;

    csr_cmd_rx i_cmd_rx (
        .clk         (clk),
        .rst         (rst),
        .cmd_req     (cmd_req),
        .cmd_kind    (cmd_kind),
        .cmd_funct3  (cmd_funct3),
        .cmd_addr    (cmd_addr),
        .cmd_rs1     (cmd_rs1),
        .cmd_zimm    (cmd_zimm),
        .cmd_pc      (cmd_pc),
        .cmd_cause   (cmd_cause),
        .dec_take    (dec_take),
        .cmd_ack     (cmd_ack),
        .dec_valid   (dec_valid),
        .dec_kind    (dec_kind),
        .dec_op      (dec_op),
        .dec_bad_op  (dec_bad_op),
        .dec_writes  (dec_writes),
        .dec_addr    (dec_addr),
        .dec_operand (dec_operand),
        .dec_pc      (dec_pc),
        .dec_cause   (dec_cause)
    );

    csr_exec i_exec (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_kind    (dec_kind),
        .dec_op      (dec_op),
        .dec_bad_op  (dec_bad_op),
        .dec_writes  (dec_writes),
        .dec_addr    (dec_addr),
        .dec_operand (dec_operand),
        .dec_pc      (dec_pc),
        .dec_cause   (dec_cause),
        .ex_take     (ex_take),
        .dec_take    (dec_take),
        .ex_valid    (ex_valid),
        .ex_rdata    (ex_rdata),
        .ex_err      (ex_err),
        .ex_jmp      (ex_jmp),
        .ex_target   (ex_target)
    );

    csr_resp_tx i_resp_tx (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_rdata   (ex_rdata),
        .ex_err     (ex_err),
        .ex_jmp     (ex_jmp),
        .ex_target  (ex_target),
        .res_ack    (res_ack),
        .ex_take    (ex_take),
        .res_req    (res_req),
        .res_rdata  (res_rdata),
        .res_err    (res_err),
        .res_jmp    (res_jmp),
        .res_target (res_target)
    );

endmodule

`default_nettype wire

//--- tests/csr_pipe_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module csr_pipe_asserts (
    input wire                     clk,
    input wire                     rst,
    input wire                     cmd_req,
    input wire                     cmd_ack,
    input wire                     res_req,
    input wire                     res_ack,
    input wire csr_isa_pkg::xlen_t res_rdata,
    input wire                     res_err,
    input wire                     res_jmp,
    input wire csr_isa_pkg::xlen_t res_target
);

    // Ack answers the request seen one edge earlier
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    result_stable: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> $stable({res_rdata, res_err, res_jmp, res_target}))
        else $error("result fields changed while res_req waited for res_ack");

    req_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(res_req) |-> $past(res_ack))
        else $error("res_req fell before res_ack");

endmodule

bind csr_pipe_top csr_pipe_asserts i_asserts (.*);

`default_nettype wire

//--- tests/tb_csr_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_pipe;
    import csr_isa_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles per handshake wait

    typedef struct {
        logic [1:0] kind;
        funct3_t    funct3;
        csr_addr_t  addr;
        xlen_t      rs1;
        logic [4:0] zimm;
        xlen_t      pc;
        xlen_t      cause;
        xlen_t      rdata;
        logic       err;
        logic       jmp;
        xlen_t      target;
    } vec_t;

    logic       clk;
    logic       rst;
    logic       cmd_req;
    logic       cmd_ack;
    cmd_kind_t  cmd_kind;
    funct3_t    cmd_funct3;
    csr_addr_t  cmd_addr;
    xlen_t      cmd_rs1;
    logic [4:0] cmd_zimm;
    xlen_t      cmd_pc;
    xlen_t      cmd_cause;
    logic       res_req;
    logic       res_ack;
    xlen_t      res_rdata;
    logic       res_err;
    logic       res_jmp;
    xlen_t      res_target;

    vec_t  vecs[$];
    int    pass_cnt;
    int    fail_cnt;
    logic  stalled;
    logic  load_bad;
    string stall_msg;

    csr_pipe_top i_csr_pipe_top (.*);

    always #2 clk = ~clk;

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        vec_t  v;
        fd = $fopen("tests/csr_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/csr_testdata.txt");
            load_bad = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "#")
                continue;
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v.kind, v.funct3,
                          v.addr, v.rs1, v.zimm, v.pc, v.cause, v.rdata, v.err, v.jmp,
                          v.target);
            if (cnt == 11) begin
                vecs.push_back(v);
            end else if (cnt > 0) begin
                $display("Malformed line in the test data file: %s", line);
                load_bad = 1'b1;
            end
        end
        $fclose(fd);
    endtask

    // Polls on falling edges until the line reaches the level or the limit runs out
    task automatic wait_line(input bit on_result, input logic level, input string what);
        int n;
        n = 0;
        while ((on_result ? res_req : cmd_ack) !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if ((on_result ? res_req : cmd_ack) !== level && !stalled) begin
            stalled   = 1'b1;
            stall_msg = what;
        end
    endtask

    task automatic drive_commands();
        foreach (vecs[i]) begin
            cmd_kind   = cmd_kind_t'(vecs[i].kind);
            cmd_funct3 = vecs[i].funct3;
            cmd_addr   = vecs[i].addr;
            cmd_rs1    = vecs[i].rs1;
            cmd_zimm   = vecs[i].zimm;
            cmd_pc     = vecs[i].pc;
            cmd_cause  = vecs[i].cause;
            cmd_req    = 1'b1;
            wait_line(1'b0, 1'b1, "The command handshake stalled: cmd_ack never rose");
            if (stalled)
                return;
            cmd_req = 1'b0;
            wait_line(1'b0, 1'b0, "The command handshake stalled: cmd_ack never fell");
            if (stalled)
                return;
        end
    endtask

    task automatic check_result(input int i);
        int bad;
        bad = 0;
        assert (res_rdata === vecs[i].rdata) else begin
            $display("error at %0t: test %0d rdata %h, expected %h",
                     $time, i, res_rdata, vecs[i].rdata);
            bad++;
        end
        assert (res_err === vecs[i].err) else begin
            $display("error at %0t: test %0d err %b, expected %b",
                     $time, i, res_err, vecs[i].err);
            bad++;
        end
        assert (res_jmp === vecs[i].jmp) else begin
            $display("error at %0t: test %0d jmp %b, expected %b",
                     $time, i, res_jmp, vecs[i].jmp);
            bad++;
        end
        // Target only means something on a redirect
        assert (!vecs[i].jmp || res_target === vecs[i].target) else begin
            $display("error at %0t: test %0d target %h, expected %h",
                     $time, i, res_target, vecs[i].target);
            bad++;
        end
        if (bad == 0) begin
            pass_cnt++;
            $display("test %0d passed", i);
        end else begin
            fail_cnt++;
            $display("test %0d failed", i);
        end
    endtask

    task automatic ack_results();
        int gap;
        foreach (vecs[i]) begin
            wait_line(1'b1, 1'b1, "The result handshake stalled: res_req never rose");
            if (stalled)
                return;
            gap = $urandom_range(0, 6);  // Sink back-pressure
            repeat (gap) @(negedge clk);
            check_result(i);
            res_ack = 1'b1;
            wait_line(1'b1, 1'b0, "The result handshake stalled: res_req stayed high");
            if (stalled)
                return;
            res_ack = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h04c5ab1a));
        clk        = 1'b0;
        rst        = 1'b1;
        cmd_req    = 1'b0;
        cmd_kind   = CMD_CSR;
        cmd_funct3 = '0;
        cmd_addr   = '0;
        cmd_rs1    = '0;
        cmd_zimm   = '0;
        cmd_pc     = '0;
        cmd_cause  = '0;
        res_ack    = 1'b0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        stalled    = 1'b0;
        load_bad   = 1'b0;
        stall_msg  = "";
        load_vectors();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        fork
            drive_commands();
            ack_results();
        join
        repeat (10) @(negedge clk);
        assert (!res_req) else begin
            $display("An extra result appeared after the last test");
            fail_cnt++;
        end
        if (stalled)
            $display("%s", stall_msg);
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (!stalled && !load_bad && fail_cnt == 0 && vecs.size() > 0
            && pass_cnt == vecs.size()) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/csr_testdata.txt
# kind funct3 addr rs1 zimm pc cause | expected rdata err jmp target, all hex
# kind 0 csr, 1 trap, 2 mret; funct3 1/2/3 rs1 write/set/clear, 5/6/7 zimm forms
0 2 300 0 00 0 0 a0001800 0 0 0
0 2 305 0 00 0 0 0 0 0 0
0 2 341 0 00 0 0 0 0 0 0
0 2 342 0 00 0 0 0 0 0 0
0 1 305 80000100 00 0 0 0 0 0 0
0 2 305 0 00 0 0 80000100 0 0 0
0 2 341 f0 00 0 0 0 0 0 0
0 3 341 30 00 0 0 f0 0 0 0
0 5 342 ffff 1f 0 0 0 0 0 0
0 6 342 0 00 0 0 1f 0 0 0
0 7 342 0 05 0 0 1f 0 0 0
0 6 300 7 08 0 0 a0001800 0 0 0
0 3 300 0 00 0 0 a0001808 0 0 0
0 1 7c0 1234 00 0 0 0 1 0 0
0 2 7c0 0 00 0 0 0 0 0 0
0 2 342 0 00 0 0 1a 0 0 0
1 0 000 0 00 80000040 b 0 0 1 80000100
0 2 341 0 00 0 0 80000040 0 0 0
0 2 342 0 00 0 0 b 0 0 0
0 2 300 0 00 0 0 a0001880 0 0 0
2 0 000 0 00 0 0 0 0 1 80000040
0 2 300 0 00 0 0 a0000088 0 0 0
0 0 300 0 00 0 0 a0000088 1 0 0
0 2 300 0 00 0 0 a0000088 0 0 0

//--- all.f
+incdir+common
common/csr_isa_pkg.sv
common/csr_ctrl_pkg.sv
hdl/csr_cmd_rx.sv
csr_unit/csr_regfile.sv
csr_unit/csr_exec.sv
hdl/csr_resp_tx.sv
hdl/csr_pipe_top.sv
tests/csr_pipe_asserts.sv
tests/tb_csr_pipe.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_csr_pipe
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	$(TOOL) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
